// ==== Bender.yml ====
package:
  name: pkt_tester

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/pkt_pkg.sv
      - logic/pkt_regs.sv
      - logic/pkt_generator.sv
      - logic/pkt_checker.sv
      - logic/pkt_tester_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/pkt_tester_tb.sv

// ==== build.f ====
+incdir+include
logic/pkt_pkg.sv
logic/pkt_regs.sv
logic/pkt_generator.sv
logic/pkt_checker.sv
logic/pkt_tester_top.sv
tb/pkt_tester_tb.sv

// ==== include/pkt_defines.svh ====
/* Widths shared by the packet tester RTL and its testbench.
   Include this wherever a stream, length or register field is sized. */

`ifndef PKT_DEFINES_SVH
`define PKT_DEFINES_SVH

////////////////////
// stream beat

// 64-bit data path, one keep bit per byte
`define PKT_DATA_W 64
`define PKT_KEEP_W 8

// byte length in the header, valid range 1..1023
`define PKT_LEN_W 10

////////////////////
// statistics and registers

`define PKT_CNT_W 16
`define REG_DATA_W 32
`define REG_ADDR_W 3

`endif

// ==== logic/pkt_checker.sv ====
/* Packet sink: reads the header, regenerates the payload and checks bytes and length.
   Good and bad packet counts saturate and are zeroed by the clear strobe. */

`default_nettype none
`timescale 1ns/1ps

`include "pkt_defines.svh"

module pkt_checker (
    input  wire logic                clk_ifc,
    input  wire logic                reset,
    input  wire pkt_pkg::pkt_beat_t  rx,
    input  wire logic                clear,
    output pkt_pkg::chk_stats_t      stats
);

    import pkt_pkg::*;

    // one extra bit so a long packet can exceed the header length
    localparam int BYTE_W = `PKT_LEN_W + 1;
    localparam int KCNT_W = $clog2(`PKT_KEEP_W + 1);

    pkt_chk_state_e state;

    logic [`PKT_DATA_W-1:0] exp_word;
    logic [`PKT_LEN_W-1:0]  exp_len;
    logic [BYTE_W-1:0]      byte_cnt;
    logic                   err;
    logic                   verdict_bad;

    logic                   take_header;
    logic                   take_payload;
    logic [KCNT_W-1:0]      kept_cnt;
    logic                   mismatch;
    logic [BYTE_W-1:0]      byte_sum;
    logic                   len_bad;

    ////////////////////
    // beat compare

    // a header may follow straight after the last beat
    assign take_header  = rx.valid && ((state == CHK_HEADER) || (state == CHK_VERDICT));
    assign take_payload = rx.valid && (state == CHK_PAYLOAD);

    always_comb begin
        kept_cnt = '0;
        mismatch = 1'b0;
        for (int b = 0; b < `PKT_KEEP_W; b++) begin
            if (rx.keep[b]) begin
                kept_cnt = kept_cnt + 1'b1;
                if (rx.data[b*8 +: 8] != exp_word[b*8 +: 8]) begin
                    mismatch = 1'b1;
                end
            end
        end
        byte_sum = byte_cnt + BYTE_W'(kept_cnt);
        // reaching the length before last means more bytes are coming
        if (rx.last) begin
            len_bad = (byte_sum != {1'b0, exp_len});
        end else begin
            len_bad = (byte_sum >= {1'b0, exp_len});
        end
    end

    ////////////////////
    // FSM

    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            state <= CHK_HEADER;
        end else begin
            case (state)
                CHK_HEADER, CHK_VERDICT: begin
                    if (take_header) begin
                        // last on a header is a broken packet
                        state <= rx.last ? CHK_VERDICT : CHK_PAYLOAD;
                    end else begin
                        state <= CHK_HEADER;
                    end
                end
                CHK_PAYLOAD: begin
                    if (take_payload && rx.last) begin
                        state <= CHK_VERDICT;
                    end
                end
                default: begin
                    state <= CHK_HEADER;
                end
            endcase
        end
    end

    // expected sequence and per-packet error tracking
    always_ff @(posedge clk_ifc) begin
        if (take_header) begin
            exp_word <= pkt_next_word({rx.data[`PKT_DATA_W-1 -: 32], ~rx.data[`PKT_DATA_W-1 -: 32]});
            exp_len  <= rx.data[`PKT_LEN_W-1:0];
            byte_cnt <= '0;
            err      <= 1'b0;
            if (rx.last) begin
                verdict_bad <= 1'b1;
            end
        end else if (take_payload) begin
            exp_word <= pkt_next_word(exp_word);
            byte_cnt <= byte_sum;
            err      <= err | mismatch | len_bad;
            if (rx.last) begin
                verdict_bad <= err | mismatch | len_bad;
            end
        end
    end

    ////////////////////
    // counters

    // clear wins over a verdict on the same cycle
    always_ff @(posedge clk_ifc) begin
        if (reset || clear) begin
            stats <= '0;
        end else if (state == CHK_VERDICT) begin
            if (verdict_bad) begin
                if (stats.bad != '1) begin
                    stats.bad <= stats.bad + 1'b1;
                end
            end else if (stats.good != '1) begin
                stats.good <= stats.good + 1'b1;
            end
        end
    end

    ////////////////////
    // checks

    // byte count above assumes keep has no holes
    rx_keep_contiguous: assert property (
        @(posedge clk_ifc) disable iff (reset)
            rx.valid |-> ((rx.keep & (rx.keep + 1'b1)) == '0)
    );

endmodule

`default_nettype wire

// ==== logic/pkt_generator.sv ====
/* Packet source: one header beat with seed and length, then xorshift payload beats.
   One packet per start pulse, starts during a packet are dropped. */

`default_nettype none
`timescale 1ns/1ps

`include "pkt_defines.svh"

module pkt_generator (
    input  wire logic                   clk_ifc,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire logic [`REG_DATA_W-1:0] seed,
    input  wire logic [`PKT_LEN_W-1:0]  length,
    output pkt_pkg::pkt_beat_t          tx,
    output logic                        busy
);

    import pkt_pkg::*;

    pkt_gen_state_e state;

    // remaining payload bytes, including the beat about to go out
    logic [`PKT_LEN_W-1:0]  rem_bytes;
    // next payload word, already stepped past the seed state
    logic [`PKT_DATA_W-1:0] word;

    logic                   launch;
    logic                   emit;
    logic [`PKT_DATA_W-1:0] hdr_data;
    logic [`PKT_DATA_W-1:0] beat_data;
    logic [`PKT_KEEP_W-1:0] beat_keep;
    logic                   beat_last;

    ////////////////////
    // beat formatting

    assign launch = start && (state == GEN_IDLE);
    // a payload beat goes out after the header and after every non-final payload beat
    assign emit = (state == GEN_HEADER) || ((state == GEN_PAYLOAD) && !tx.last);
    assign busy = (state != GEN_IDLE);

    always_comb begin
        // seed on top, length in the low bits
        hdr_data = '0;
        hdr_data[`PKT_DATA_W-1 -: `REG_DATA_W] = seed;
        hdr_data[`PKT_LEN_W-1:0] = length;

        beat_last = (rem_bytes <= `PKT_KEEP_W);
        for (int b = 0; b < `PKT_KEEP_W; b++) begin
            // keep is contiguous from byte 0 on the short beat
            beat_keep[b] = beat_last ? (b < rem_bytes) : 1'b1;
            beat_data[b*8 +: 8] = beat_keep[b] ? word[b*8 +: 8] : 8'h00;
        end
    end

    ////////////////////
    // FSM and output beat

    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            state <= GEN_IDLE;
            tx    <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (launch) begin
                        state    <= GEN_HEADER;
                        tx.valid <= 1'b1;
                        tx.data  <= hdr_data;
                        tx.keep  <= '1;
                        tx.last  <= 1'b0;
                    end
                end
                GEN_HEADER, GEN_PAYLOAD: begin
                    if (emit) begin
                        state    <= GEN_PAYLOAD;
                        tx.valid <= 1'b1;
                        tx.data  <= beat_data;
                        tx.keep  <= beat_keep;
                        tx.last  <= beat_last;
                    end else begin
                        // final beat went out this cycle
                        state <= GEN_IDLE;
                        tx    <= '0;
                    end
                end
                default: begin
                    state <= GEN_IDLE;
                    tx    <= '0;
                end
            endcase
        end
    end

    // sequence state and byte count, loaded at start
    always_ff @(posedge clk_ifc) begin
        if (launch) begin
            rem_bytes <= length;
            word      <= pkt_next_word({seed, ~seed});
        end else if (emit) begin
            rem_bytes <= rem_bytes - `PKT_LEN_W'(`PKT_KEEP_W);
            word      <= pkt_next_word(word);
        end
    end

    ////////////////////
    // checks

    tx_last_has_valid: assert property (
        @(posedge clk_ifc) disable iff (reset) tx.last |-> tx.valid
    );

    // a zero length would show up here as an empty final beat
    tx_keep_nonzero: assert property (
        @(posedge clk_ifc) disable iff (reset) tx.valid |-> (tx.keep != '0)
    );

endmodule

`default_nettype wire

// ==== logic/pkt_pkg.sv ====
/* Types and the payload sequence shared by the generator, the checker and the register block.
   Imported inside each module body that needs them. */

`default_nettype none

`include "pkt_defines.svh"

package pkt_pkg;

    ////////////////////
    // stream beat

    // no ready, a valid beat must be taken the cycle it shows up
    typedef struct packed {
        logic                     valid;
        logic [`PKT_DATA_W-1:0]   data;
        logic [`PKT_KEEP_W-1:0]   keep;
        logic                     last;
    } pkt_beat_t;

    ////////////////////
    // FSM states

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_HEADER,
        GEN_PAYLOAD
    } pkt_gen_state_e;

    typedef enum logic [1:0] {
        CHK_HEADER,
        CHK_PAYLOAD,
        CHK_VERDICT
    } pkt_chk_state_e;

    // register map, addresses 6 and 7 read zero
    typedef enum logic [`REG_ADDR_W-1:0] {
        REG_CTRL   = 3'd0,
        REG_SEED   = 3'd1,
        REG_LENGTH = 3'd2,
        REG_STATUS = 3'd3,
        REG_GOOD   = 3'd4,
        REG_BAD    = 3'd5
    } reg_addr_e;

    typedef struct packed {
        logic [`PKT_CNT_W-1:0] good;
        logic [`PKT_CNT_W-1:0] bad;
    } chk_stats_t;

    // one xorshift64 step, 13 left / 7 right / 17 left
    // start state is {seed, ~seed} so it never sits at zero
    function automatic logic [`PKT_DATA_W-1:0] pkt_next_word(
        input logic [`PKT_DATA_W-1:0] state
    );
        logic [`PKT_DATA_W-1:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

endpackage

`default_nettype wire

// ==== logic/pkt_regs.sv ====
/* Software register block of the tester: seed, length, start/clear strobes,
   and a combinational read port for status and packet counters. */

`default_nettype none
`timescale 1ns/1ps

`include "pkt_defines.svh"

module pkt_regs (
    input  wire logic                   clk_ifc,
    input  wire logic                   reset,
    input  wire logic                   wr_en,
    input  wire pkt_pkg::reg_addr_e     addr,
    input  wire logic [`REG_DATA_W-1:0] wdata,
    input  wire pkt_pkg::reg_addr_e     rd_addr,
    output logic      [`REG_DATA_W-1:0] rdata,
    output logic      [`REG_DATA_W-1:0] seed,
    output logic      [`PKT_LEN_W-1:0]  length,
    output logic                        start,
    output logic                        clear,
    input  wire logic                   busy,
    input  wire pkt_pkg::chk_stats_t    stats
);

    import pkt_pkg::*;

    localparam logic [`REG_DATA_W-1:0] SEED_RESET = 1;
    localparam logic [`PKT_LEN_W-1:0]  LEN_RESET  = 64;

    logic ctrl_wr;

    ////////////////////
    // write side

    assign ctrl_wr = wr_en && (addr == REG_CTRL);

    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            seed   <= SEED_RESET;
            length <= LEN_RESET;
            start  <= 1'b0;
            clear  <= 1'b0;
        end else begin
            if (wr_en && (addr == REG_SEED)) begin
                seed <= wdata;
            end
            // upper bits of the length write are dropped
            if (wr_en && (addr == REG_LENGTH)) begin
                length <= wdata[`PKT_LEN_W-1:0];
            end
            // strobes pulse for one cycle after a ctrl write
            start <= ctrl_wr && wdata[0];
            clear <= ctrl_wr && wdata[1];
        end
    end

    ////////////////////
    // read side

    // combinational read data for the same cycle
    always_comb begin
        rdata = '0;
        case (rd_addr)
            REG_SEED: begin
                rdata = seed;
            end
            REG_LENGTH: begin
                rdata[`PKT_LEN_W-1:0] = length;
            end
            REG_STATUS: begin
                rdata[0] = busy;
            end
            REG_GOOD: begin
                rdata[`PKT_CNT_W-1:0] = stats.good;
            end
            REG_BAD: begin
                rdata[`PKT_CNT_W-1:0] = stats.bad;
            end
            default: begin
                // ctrl and unmapped addresses read zero
                rdata = '0;
            end
        endcase
    end

    ////////////////////
    // checks

    // generator and checker both rely on single-cycle strobes
    start_single_cycle: assert property (
        @(posedge clk_ifc) disable iff (reset) start |=> !start
    );

    clear_single_cycle: assert property (
        @(posedge clk_ifc) disable iff (reset) clear |=> !clear
    );

endmodule

`default_nettype wire

// ==== logic/pkt_tester_top.sv ====
/* Top of the single-lane traffic tester. tx leaves on its own port and rx comes back
   on another, so the loopback path sits outside. */

`default_nettype none
`timescale 1ns/1ps

`include "pkt_defines.svh"

module pkt_tester_top (
    input  wire logic                   clk_ifc,
    input  wire logic                   reset,
    input  wire logic                   wr_en,
    input  wire pkt_pkg::reg_addr_e     addr,
    input  wire logic [`REG_DATA_W-1:0] wdata,
    input  wire pkt_pkg::reg_addr_e     rd_addr,
    output logic      [`REG_DATA_W-1:0] rdata,
    output pkt_pkg::pkt_beat_t          tx,
    input  wire pkt_pkg::pkt_beat_t     rx
);

    import pkt_pkg::*;

    logic [`REG_DATA_W-1:0] seed;
    logic [`PKT_LEN_W-1:0]  length;
    logic                   start;
    logic                   clear;
    logic                   busy;
    chk_stats_t             stats;

    ////////////////////
    // control

    pkt_regs u_regs (
        .clk_ifc (clk_ifc),
        .reset   (reset),
        .wr_en   (wr_en),
        .addr    (addr),
        .wdata   (wdata),
        .rd_addr (rd_addr),
        .rdata   (rdata),
        .seed    (seed),
        .length  (length),
        .start   (start),
        .clear   (clear),
        .busy    (busy),
        .stats   (stats)
    );

    ////////////////////
    // datapath

    pkt_generator u_generator (
        .clk_ifc (clk_ifc),
        .reset   (reset),
        .start   (start),
        .seed    (seed),
        .length  (length),
        .tx      (tx),
        .busy    (busy)
    );

    // checker sees whatever the outside loopback hands back
    pkt_checker u_checker (
        .clk_ifc (clk_ifc),
        .reset   (reset),
        .rx      (rx),
        .clear   (clear),
        .stats   (stats)
    );

endmodule

`default_nettype wire

// ==== tb/pkt_tester_tb.sv ====
/* Self-checking testbench for the packet tester. tx loops back to rx through a fault stage,
   and a table of packets is run while beats, registers and counters are checked. */

`default_nettype none
`timescale 1ns/1ps

`include "pkt_defines.svh"

module pkt_tester_tb;

    import pkt_pkg::*;

    localparam int N_ENTRIES    = 8;
    localparam int RESET_CYCLES = 8;
    // register traffic around each packet
    localparam int ENTRY_SLACK  = 40;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_FLIP,
        FAULT_SHORT
    } fault_e;

    typedef struct packed {
        logic [31:0]           seed;
        logic [`PKT_LEN_W-1:0] len;
        fault_e                fault;
        logic                  dbl_start;
    } entry_t;

    logic                   clk_ifc;
    logic                   reset;
    logic                   wr_en;
    reg_addr_e              addr;
    logic [`REG_DATA_W-1:0] wdata;
    reg_addr_e              rd_addr;
    logic [`REG_DATA_W-1:0] rdata;
    pkt_beat_t              tx;
    pkt_beat_t              rx;

    entry_t                 stim [N_ENTRIES];
    logic [15:0]            lfsr;
    chk_stats_t             exp_stats;

    // packet under test, set by the main flow while idle
    logic [31:0]            cur_seed;
    logic [`PKT_LEN_W-1:0]  cur_len;
    fault_e                 cur_fault;

    // tx monitor state
    logic                   in_pkt;
    int                     pay_idx;
    int                     rem;
    logic [`PKT_DATA_W-1:0] exp_word;
    int                     tx_beats;
    int                     pkt_cnt;

    int                     beat_errs;
    int                     stat_errs;
    int                     reg_errs;
    int                     misc_errs;
    int                     cycle_cnt;
    int                     cycle_limit;

    pkt_tester_top dut0 (
        .clk_ifc (clk_ifc),
        .reset   (reset),
        .wr_en   (wr_en),
        .addr    (addr),
        .wdata   (wdata),
        .rd_addr (rd_addr),
        .rdata   (rdata),
        .tx      (tx),
        .rx      (rx)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #4 clk_ifc = ~clk_ifc;
    end

    ////////////////////
    // reference models

    // 16-bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] model_xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic pkt_beat_t header_beat(input logic [31:0] seed,
                                              input logic [`PKT_LEN_W-1:0] len);
        pkt_beat_t b;
        b = '0;
        b.valid = 1'b1;
        b.data[63:32] = seed;
        b.data[`PKT_LEN_W-1:0] = len;
        b.keep = '1;
        return b;
    endfunction

    // rem counts bytes still owed, this beat included
    function automatic pkt_beat_t payload_beat(input logic [63:0] word, input int rem_bytes);
        pkt_beat_t b;
        b = '0;
        b.valid = 1'b1;
        for (int i = 0; i < `PKT_KEEP_W; i++) begin
            if (i < rem_bytes) begin
                b.keep[i] = 1'b1;
                b.data[i*8 +: 8] = word[i*8 +: 8];
            end
        end
        b.last = (rem_bytes <= `PKT_KEEP_W);
        return b;
    endfunction

    function automatic pkt_beat_t apply_fault(input pkt_beat_t b, input fault_e f,
                                              input logic is_hdr, input int idx);
        pkt_beat_t r;
        int        top;
        r = b;
        top = 0;
        if (b.valid && !is_hdr) begin
            if (f == FAULT_FLIP && idx == 0) begin
                r.data[5] = ~r.data[5];
            end
            if (f == FAULT_SHORT && b.last) begin
                for (int i = 0; i < `PKT_KEEP_W; i++) begin
                    if (b.keep[i]) begin
                        top = i;
                    end
                end
                // drop the highest kept byte
                r.keep[top] = 1'b0;
                r.data[top*8 +: 8] = 8'h00;
            end
        end
        return r;
    endfunction

    ////////////////////
    // checks and bus tasks

    task automatic compare_beat(input string name, input pkt_beat_t exp, input pkt_beat_t got);
        if (got !== exp) begin
            beat_errs++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic compare_stats(input chk_stats_t exp, input chk_stats_t got);
        if (got !== exp) begin
            stat_errs++;
            $display("[FAIL] stats expected %h got %h", exp, got);
        end
    endtask

    task automatic compare_reg(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            reg_errs++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic reg_write(input reg_addr_e a, input logic [31:0] d);
        @(posedge clk_ifc);
        wr_en <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk_ifc);
        wr_en <= 1'b0;
    endtask

    // read is combinational, sample one edge after the address settles
    task automatic reg_read(input reg_addr_e a, output logic [31:0] d);
        @(posedge clk_ifc);
        rd_addr <= a;
        @(posedge clk_ifc);
        d = rdata;
    endtask

    task automatic read_stats(output chk_stats_t s);
        logic [31:0] v;
        reg_read(REG_GOOD, v);
        s.good = v[`PKT_CNT_W-1:0];
        reg_read(REG_BAD, v);
        s.bad = v[`PKT_CNT_W-1:0];
    endtask

    task automatic set_entry(input int idx, input logic [31:0] seed,
                             input logic [`PKT_LEN_W-1:0] len, input fault_e f, input logic dbl);
        stim[idx].seed      = seed;
        stim[idx].len       = len;
        stim[idx].fault     = f;
        stim[idx].dbl_start = dbl;
    endtask

    task automatic finish_run();
        $display("errors: beat %0d, stats %0d, register %0d, other %0d",
                 beat_errs, stat_errs, reg_errs, misc_errs);
        if (beat_errs + stat_errs + reg_errs + misc_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    ////////////////////
    // loopback and tx monitor

    always @(posedge clk_ifc) begin
        if (reset) begin
            rx       <= '0;
            in_pkt   <= 1'b0;
            pay_idx  <= 0;
            rem      <= 0;
            tx_beats <= 0;
            pkt_cnt  <= 0;
        end else begin
            rx <= apply_fault(tx, cur_fault, !in_pkt, pay_idx);
            if (tx.valid && !in_pkt) begin
                compare_beat("tx header", header_beat(cur_seed, cur_len), tx);
                in_pkt   <= 1'b1;
                pay_idx  <= 0;
                rem      <= cur_len;
                exp_word <= model_xorshift({cur_seed, ~cur_seed});
                tx_beats <= 1;
                pkt_cnt  <= pkt_cnt + 1;
            end else if (tx.valid) begin
                compare_beat("tx payload", payload_beat(exp_word, rem), tx);
                pay_idx  <= pay_idx + 1;
                rem      <= rem - `PKT_KEEP_W;
                exp_word <= model_xorshift(exp_word);
                tx_beats <= tx_beats + 1;
                if (rem <= `PKT_KEEP_W) begin
                    in_pkt <= 1'b0;
                end
            end else if (in_pkt) begin
                misc_errs++;
                $display("tx went idle in the middle of packet %0d", pkt_cnt);
                in_pkt <= 1'b0;
            end
        end
    end

    always @(posedge clk_ifc) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            misc_errs++;
            $display("timeout after %0d cycles, the test table never completed", cycle_cnt);
            finish_run();
        end
    end

    ////////////////////
    // main flow

    initial begin : main_flow
        logic [31:0] v;
        logic [31:0] rd;
        chk_stats_t  got;
        int          n_beats;
        reset     = 1'b1;
        wr_en     = 1'b0;
        addr      = REG_CTRL;
        wdata     = '0;
        rd_addr   = REG_CTRL;
        rx        = '0;
        lfsr      = 16'd64;
        exp_stats = '0;
        cur_seed  = '0;
        cur_len   = '0;
        cur_fault = FAULT_NONE;
        beat_errs = 0;
        stat_errs = 0;
        reg_errs  = 0;
        misc_errs = 0;
        cycle_cnt = 0;

        // fixed edge cases on even slots, lfsr picks on odd slots
        set_entry(0, 32'h0000_0001, 10'd1, FAULT_NONE, 1'b0);
        set_entry(2, 32'hdead_beef, 10'd8, FAULT_NONE, 1'b0);
        set_entry(4, 32'h1234_5678, 10'd9, FAULT_FLIP, 1'b0);
        set_entry(6, 32'hffff_ffff, 10'd1023, FAULT_NONE, 1'b1);
        for (int i = 1; i < N_ENTRIES; i += 2) begin
            draw_bits(32, v);
            stim[i].seed = v;
            draw_bits(`PKT_LEN_W, v);
            stim[i].len = (v[`PKT_LEN_W-1:0] == '0) ? 10'd1 : v[`PKT_LEN_W-1:0];
            stim[i].fault = (i == 3) ? FAULT_SHORT : FAULT_NONE;
            stim[i].dbl_start = (i == 5);
        end
        // a second start needs a packet long enough to still be busy
        stim[5].len = stim[5].len | 10'd64;

        cycle_limit = RESET_CYCLES + 40;
        for (int i = 0; i < N_ENTRIES; i++) begin
            cycle_limit += 1 + (stim[i].len + 7) / 8 + ENTRY_SLACK;
        end

        repeat (RESET_CYCLES) @(posedge clk_ifc);
        reset <= 1'b0;

        // reset values, ctrl and unmapped addresses
        reg_read(REG_SEED, rd);
        compare_reg("REG_SEED reset", 32'd1, rd);
        reg_read(REG_LENGTH, rd);
        compare_reg("REG_LENGTH reset", 32'd64, rd);
        reg_read(REG_CTRL, rd);
        compare_reg("REG_CTRL", 32'd0, rd);
        reg_read(reg_addr_e'(3'd6), rd);
        compare_reg("addr 6", 32'd0, rd);
        reg_read(reg_addr_e'(3'd7), rd);
        compare_reg("addr 7", 32'd0, rd);

        for (int i = 0; i < N_ENTRIES; i++) begin
            if (i == 4) begin
                reg_write(REG_CTRL, 32'h2);
                exp_stats = '0;
                read_stats(got);
                compare_stats(exp_stats, got);
            end
            cur_seed  = stim[i].seed;
            cur_len   = stim[i].len;
            cur_fault = stim[i].fault;
            reg_write(REG_SEED, cur_seed);
            reg_write(REG_LENGTH, 32'(cur_len));
            reg_read(REG_SEED, rd);
            compare_reg("REG_SEED", cur_seed, rd);
            reg_read(REG_LENGTH, rd);
            compare_reg("REG_LENGTH", 32'(cur_len), rd);

            reg_write(REG_CTRL, 32'h1);
            reg_read(REG_STATUS, rd);
            compare_reg("REG_STATUS busy", 32'h1, rd);
            if (stim[i].dbl_start) begin
                reg_write(REG_CTRL, 32'h1);
            end

            // verdict lands a cycle after the last rx beat
            do @(posedge clk_ifc); while (!(rx.valid && rx.last));
            if (cur_fault == FAULT_NONE) begin
                exp_stats.good = exp_stats.good + 1'b1;
            end else begin
                exp_stats.bad = exp_stats.bad + 1'b1;
            end
            read_stats(got);
            compare_stats(exp_stats, got);
            reg_read(REG_STATUS, rd);
            compare_reg("REG_STATUS idle", 32'h0, rd);

            n_beats = 1 + (cur_len + 7) / 8;
            if (tx_beats != n_beats) begin
                misc_errs++;
                $display("entry %0d sent %0d beats on tx instead of %0d", i, tx_beats, n_beats);
            end
            if (pkt_cnt != i + 1) begin
                misc_errs++;
                $display("entry %0d: %0d packets seen on tx so far, %0d expected",
                         i, pkt_cnt, i + 1);
            end
        end

        // quiet tail, nothing more may leave the generator
        repeat (10) @(posedge clk_ifc);
        if (pkt_cnt != N_ENTRIES) begin
            misc_errs++;
            $display("extra packet on tx after the table, %0d packets in all", pkt_cnt);
        end
        finish_run();
    end

endmodule

`default_nettype wire
